/* rtl/mul_pkg.sv */
// dadda multiplier shared definitions
package mul_pkg;

    localparam int OP_W       = 16;
    localparam int PROD_W     = 2 * OP_W;
    localparam int NUM_STAGES = 6;
    localparam int MAX_H      = OP_W;
    localparam int MATRIX_W   = PROD_W * MAX_H;
    localparam int LATENCY    = NUM_STAGES + 2;

    // target column height of each reduction level
    localparam int DADDA_H [NUM_STAGES] = '{13, 9, 6, 4, 3, 2};

    // one product word, read whole or as two halves
    typedef union packed {
        logic [PROD_W-1:0] full;
        struct packed {
            logic [OP_W-1:0] hi;
            logic [OP_W-1:0] lo;
        } halves;
    } prod_word_t;

    // live bits in column col after the given number of levels
    function automatic int pp_col_height(input int col, input int stages);
        logic [PROD_W-1:0][7:0] h;
        int total;
        int cin;
        int excess;
        for (int c = 0; c < PROD_W; c++)
        begin
            h[c] = (c < OP_W) ? 8'(c + 1) : 8'(PROD_W - 1 - c);
        end
        for (int s = 0; s < stages; s++)
        begin
            cin = 0;
            for (int c = 0; c < PROD_W; c++)
            begin
                total  = int'(h[c]) + cin;
                excess = (total > DADDA_H[s]) ? total - DADDA_H[s] : 0;
                cin    = (excess + 1) / 2;
                h[c]   = 8'(total - excess);
            end
        end
        return int'(h[col]);
    endfunction

endpackage

/* rtl/mul_operand_prep.sv */
// operand magnitudes and partial products
`timescale 1ns/1ps

module mul_operand_prep
    import mul_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                mode,
    input  logic [OP_W-1:0]     a,
    input  logic [OP_W-1:0]     b,
    output logic                valid_out,
    output logic                neg_out,
    output logic [MATRIX_W-1:0] matrix_out
);

    logic                a_neg;
    logic                b_neg;
    logic [OP_W-1:0]     a_mag;
    logic [OP_W-1:0]     b_mag;
    logic [MATRIX_W-1:0] pp;

    // signed operands only count as negative in mode 1
    assign a_neg = mode & a[OP_W-1];
    assign b_neg = mode & b[OP_W-1];
    assign a_mag = (a ^ {OP_W{a_neg}}) + OP_W'(a_neg);
    assign b_mag = (b ^ {OP_W{b_neg}}) + OP_W'(b_neg);

    // bit a[j]&b[i] lands in column i+j, packed to the low end of the column
    always_comb
    begin
        pp = '0;
        for (int i = 0; i < OP_W; i++)
        begin
            for (int j = 0; j < OP_W; j++)
            begin
                if (i + j < OP_W)
                begin
                    pp[(i + j) * MAX_H + i] = a_mag[j] & b_mag[i];
                end
                else
                begin
                    pp[(i + j) * MAX_H + OP_W - 1 - j] = a_mag[j] & b_mag[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_out <= 1'b0;
        else
            valid_out <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        neg_out    <= a_neg ^ b_neg;
        matrix_out <= pp;
    end

endmodule

/* rtl/dadda_stage.sv */
// one dadda reduction level
`timescale 1ns/1ps

module dadda_stage
    import mul_pkg::*;
#(
    parameter int TARGET = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic                neg_in,
    input  logic [MATRIX_W-1:0] matrix_in,
    output logic                valid_out,
    output logic                neg_out,
    output logic [MATRIX_W-1:0] matrix_out
);

    function automatic int level_of(input int t);
        int lvl;
        lvl = 0;
        for (int k = 0; k < NUM_STAGES; k++)
        begin
            if (DADDA_H[k] == t)
                lvl = k;
        end
        return lvl;
    endfunction

    // levels already applied to the incoming matrix
    localparam int LEVEL = level_of(TARGET);

    function automatic int carries_into(input int col);
        int cin;
        int tot;
        cin = 0;
        for (int k = 0; k < col; k++)
        begin
            tot = pp_col_height(k, LEVEL) + cin;
            cin = (tot > TARGET) ? (tot - TARGET + 1) / 2 : 0;
        end
        return cin;
    endfunction

    logic [PROD_W-1:0][MAX_H-1:0] carry_in;
    logic [MATRIX_W-1:0]          reduced;

    assign carry_in[0] = '0;

    for (genvar c = 0; c < PROD_W; c++)
    begin : g_col
        localparam int HIN    = pp_col_height(c, LEVEL);
        localparam int CIN    = carries_into(c);
        localparam int TOT    = HIN + CIN;
        localparam int EXCESS = (TOT > TARGET) ? TOT - TARGET : 0;
        localparam int NFA    = EXCESS / 2;
        localparam int NHA    = EXCESS % 2;
        localparam int NUSED  = 3 * NFA + 2 * NHA;
        localparam int NKEEP  = HIN - NUSED;

        logic [MAX_H-1:0] col_in;
        logic [MAX_H-1:0] col_out;
        logic [MAX_H-1:0] cout;

        assign col_in = matrix_in[c * MAX_H +: MAX_H];

        // sums first, then untouched bits, then carries from below
        always_comb
        begin
            col_out = '0;
            for (int f = 0; f < NFA; f++)
            begin
                col_out[f] = ^col_in[3 * f +: 3];
            end
            if (NHA != 0)
            begin
                col_out[NFA] = col_in[3 * NFA] ^ col_in[3 * NFA + 1];
            end
            for (int i = 0; i < NKEEP; i++)
            begin
                col_out[NFA + NHA + i] = col_in[NUSED + i];
            end
            for (int j = 0; j < CIN; j++)
            begin
                col_out[NFA + NHA + NKEEP + j] = carry_in[c][j];
            end
        end

        // carries passed up to the next column
        always_comb
        begin
            cout = '0;
            for (int f = 0; f < NFA; f++)
            begin
                cout[f] = (col_in[3 * f] & col_in[3 * f + 1]) |
                          (col_in[3 * f + 2] & (col_in[3 * f] ^ col_in[3 * f + 1]));
            end
            if (NHA != 0)
            begin
                cout[NFA] = col_in[3 * NFA] & col_in[3 * NFA + 1];
            end
        end

        assign reduced[c * MAX_H +: MAX_H] = col_out;

        // a carry out of the top column has weight 2^PROD_W and is dropped
        if (c < PROD_W - 1)
        begin : g_carry
            assign carry_in[c + 1] = cout;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        neg_out    <= neg_in;
        matrix_out <= reduced;
    end

endmodule

/* rtl/mul_final_add.sv */
// final carry-propagate add and sign restore
`timescale 1ns/1ps

module mul_final_add
    import mul_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic                neg_in,
    input  logic [MATRIX_W-1:0] matrix_in,
    output logic                valid_out,
    output prod_word_t          product
);

    logic [PROD_W-1:0] row_a;
    logic [PROD_W-1:0] row_b;
    logic [PROD_W-1:0] sum;
    logic [PROD_W-1:0] result;

    // only the two lowest bits of each column are still live
    always_comb
    begin
        for (int c = 0; c < PROD_W; c++)
        begin
            row_a[c] = matrix_in[c * MAX_H];
            row_b[c] = matrix_in[c * MAX_H + 1];
        end
    end

    assign sum = row_a + row_b;

    // two's complement when exactly one operand was negative
    assign result = (sum ^ {PROD_W{neg_in}}) + PROD_W'(neg_in);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_out    <= 1'b0;
            product.full <= '0;
        end
        else
        begin
            valid_out    <= valid_in;
            product.full <= result;
        end
    end

endmodule

/* rtl/dadda_mul.sv */
// pipelined dadda multiplier top
`timescale 1ns/1ps

module dadda_mul
    import mul_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            mode,
    input  logic [OP_W-1:0] a,
    input  logic [OP_W-1:0] b,
    output logic            out_valid,
    output logic [OP_W-1:0] hi,
    output logic [OP_W-1:0] lo
);

    // index k holds the matrix entering reduction level k
    logic [NUM_STAGES:0] st_valid;
    logic [NUM_STAGES:0] st_neg;
    logic [MATRIX_W-1:0] st_matrix [NUM_STAGES+1];
    prod_word_t          product;

    mul_operand_prep u_prep (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .mode       (mode),
        .a          (a),
        .b          (b),
        .valid_out  (st_valid[0]),
        .neg_out    (st_neg[0]),
        .matrix_out (st_matrix[0])
    );

    for (genvar k = 0; k < NUM_STAGES; k++)
    begin : g_stage
        dadda_stage #(
            .TARGET (DADDA_H[k])
        ) u_stage (
            .clk        (clk),
            .rst_n      (rst_n),
            .valid_in   (st_valid[k]),
            .neg_in     (st_neg[k]),
            .matrix_in  (st_matrix[k]),
            .valid_out  (st_valid[k + 1]),
            .neg_out    (st_neg[k + 1]),
            .matrix_out (st_matrix[k + 1])
        );
    end

    mul_final_add u_final (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (st_valid[NUM_STAGES]),
        .neg_in    (st_neg[NUM_STAGES]),
        .matrix_in (st_matrix[NUM_STAGES]),
        .valid_out (out_valid),
        .product   (product)
    );

    assign hi = product.halves.hi;
    assign lo = product.halves.lo;

endmodule

/* test/tb_compare.svh */
// result compare tasks
`ifndef TB_COMPARE_SVH
`define TB_COMPARE_SVH

int check_count = 0;
int err_count   = 0;

task automatic compare_prod(input string name, input prod_word_t exp, input prod_word_t act);
    check_count++;
    if (act.full !== exp.full)
    begin
        $display("MISMATCH %s: expected %h_%h actual %h_%h", name,
                 exp.halves.hi, exp.halves.lo, act.halves.hi, act.halves.lo);
        err_count++;
    end
endtask

// valid flag against its expected cycle
task automatic compare_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
        $display("MISMATCH %s: expected valid %b actual valid %b at %0t", name, exp, act, $time);
        err_count++;
    end
endtask

`endif

/* test/tb_dadda_mul.sv */
// dadda multiplier testbench
`timescale 1ns/1ps

module tb_dadda_mul
    import mul_pkg::*;
;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_UNSIGNED   = 10;
    localparam int N_SIGNED     = 8;
    localparam int N_RAND       = 200;
    localparam int N_BURST      = 50;
    localparam int N_TESTS      = 5;
    // a burst item takes up to three slots with its gap
    localparam int N_SLOTS      = N_UNSIGNED + N_SIGNED + 1 + N_RAND + 3 * N_BURST;
    localparam int WATCHDOG_CYCLES = 2 * (N_SLOTS + LATENCY * N_TESTS + RESET_CYCLES) + 20;
    localparam logic [31:0] SEED = 32'ha5797c8b;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            mode;
    logic [OP_W-1:0] a;
    logic [OP_W-1:0] b;
    logic            out_valid;
    logic [OP_W-1:0] hi;
    logic [OP_W-1:0] lo;

    integer              seed;
    string               cur_test;
    prod_word_t          exp_q [$];
    prod_word_t          mon_act;
    logic [LATENCY-1:0]  vhist = '0;

    `include "tb_compare.svh"

    dadda_mul dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode      (mode),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .hi        (hi),
        .lo        (lo)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // plain integer product with signed operands in mode 1
    function automatic prod_word_t ref_product(input logic m, input logic [OP_W-1:0] x,
                                               input logic [OP_W-1:0] y);
        longint     px;
        longint     py;
        longint     pr;
        prod_word_t r;
        px = m ? longint'($signed(x)) : longint'(x);
        py = m ? longint'($signed(y)) : longint'(y);
        pr = px * py;
        r.full = pr[PROD_W-1:0];
        return r;
    endfunction

    task automatic drive_item(input logic m, input logic [OP_W-1:0] x, input logic [OP_W-1:0] y);
        @(posedge clk);
        in_valid <= 1'b1;
        mode     <= m;
        a        <= x;
        b        <= y;
        exp_q.push_back(ref_product(m, x, y));
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, err_count - errs_before);
    endtask

    // out_valid must repeat in_valid LATENCY edges later
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            compare_flag(cur_test, vhist[LATENCY-1], out_valid);
            if (out_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("ERROR %s: out_valid high with no item outstanding", cur_test);
                    err_count++;
                end
                else
                begin
                    mon_act.halves.hi = hi;
                    mon_act.halves.lo = lo;
                    compare_prod(cur_test, exp_q.pop_front(), mon_act);
                end
            end
        end
        vhist <= {vhist[LATENCY-2:0], in_valid & rst_n};
    end

    task automatic test_reset();
        int         errs;
        prod_word_t got;
        errs = err_count;
        cur_test = "reset";
        // valid registers are known low from the first edge on
        @(posedge clk);
        repeat (RESET_CYCLES - 1)
        begin
            @(posedge clk);
            compare_flag(cur_test, 1'b0, out_valid);
        end
        rst_n <= 1'b1;
        repeat (LATENCY)
        begin
            @(posedge clk);
            got.halves.hi = hi;
            got.halves.lo = lo;
            compare_flag(cur_test, 1'b0, out_valid);
            compare_prod(cur_test, '0, got);
        end
        report_test(cur_test, errs);
    endtask

    task automatic test_unsigned_corners();
        int errs;
        errs = err_count;
        cur_test = "unsigned_corners";
        drive_item(1'b0, 16'h0000, 16'h1234);
        drive_item(1'b0, 16'hbeef, 16'h0000);
        drive_item(1'b0, 16'h0001, 16'ha5a5);
        drive_item(1'b0, 16'hffff, 16'h0001);
        drive_item(1'b0, 16'hffff, 16'hffff);
        drive_item(1'b0, 16'h8000, 16'h8000);
        drive_item(1'b0, 16'h0001, 16'h8000);
        drive_item(1'b0, 16'h0100, 16'h0010);
        drive_item(1'b0, 16'h8000, 16'hffff);
        drive_item(1'b0, 16'h0008, 16'h0800);
        drain();
        report_test(cur_test, errs);
    endtask

    task automatic test_signed_corners();
        int errs;
        errs = err_count;
        cur_test = "signed_corners";
        drive_item(1'b1, 16'hfffd, 16'h0007);
        drive_item(1'b1, 16'h0064, 16'hff38);
        drive_item(1'b1, 16'hfff6, 16'hffec);
        drive_item(1'b1, 16'h8000, 16'h8000);
        drive_item(1'b1, 16'h8000, 16'h0001);
        drive_item(1'b1, 16'hffff, 16'hffff);
        drive_item(1'b1, 16'h7fff, 16'h8000);
        drive_item(1'b1, 16'h7fff, 16'h7fff);
        drain();
        report_test(cur_test, errs);
    endtask

    task automatic test_latency();
        int errs;
        errs = err_count;
        cur_test = "latency";
        drive_item(1'b1, 16'h1357, 16'hfedc);
        // this edge samples the item
        idle_cycle();
        for (int n = 1; n <= LATENCY + 2; n++)
        begin
            @(posedge clk);
            compare_flag(cur_test, n == LATENCY, out_valid);
        end
        drain();
        report_test(cur_test, errs);
    endtask

    task automatic test_throughput();
        int          errs;
        int          gap;
        logic [31:0] ra;
        logic [31:0] rb;
        errs = err_count;
        cur_test = "throughput";
        for (int i = 0; i < N_RAND; i++)
        begin
            ra = $random(seed);
            rb = $random(seed);
            drive_item(ra[31], ra[15:0], rb[15:0]);
        end
        for (int i = 0; i < N_BURST; i++)
        begin
            ra = $random(seed);
            rb = $random(seed);
            drive_item(rb[31], ra[15:0], rb[15:0]);
            gap = int'(ra[23:16]) % 3;
            repeat (gap)
                idle_cycle();
        end
        drain();
        report_test(cur_test, errs);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        mode     = 1'b0;
        a        = '0;
        b        = '0;
        seed     = SEED;
        cur_test = "reset";
        test_reset();
        test_unsigned_corners();
        test_signed_corners();
        test_latency();
        test_throughput();
        $display("checks %0d errors %0d", check_count, err_count);
        if (err_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* build.f */
+incdir+test
rtl/mul_pkg.sv
rtl/mul_operand_prep.sv
rtl/dadda_stage.sv
rtl/mul_final_add.sv
rtl/dadda_mul.sv
test/tb_dadda_mul.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dadda multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_dadda_mul -f build.f -o sim_dadda_mul > build.log 2>&1 \
    && ./obj_dir/sim_dadda_mul > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
